/* hdl/aguPkg.sv */
package aguPkg;

    typedef logic [31:0] vaddrT;
    typedef logic [19:0] vpnT;
    // Only 32-bit physical space, so the top two Sv32 PPN bits are dropped
    typedef logic [19:0] ppnT;
    typedef logic [5:0]  tagT;
    typedef logic [31:0] pteT;

    typedef enum logic [2:0] {
        LB, LH, LW, LBU, LHU, SB, SH, SW
    } memOpE;

    typedef enum logic [1:0] {
        exNone, exMisalign, exPageFault, exAccessFault
    } exceptE;

    typedef enum logic {
        privUser, privSupervisor
    } privE;

    typedef enum logic [2:0] {
        wsIdle, wsLevel1Req, wsLevel1Wait, wsLevel0Req, wsLevel0Wait, wsFill
    } walkStateE;

    typedef struct packed {
        logic sv32en;
        ppnT  rootPpn;
        privE priv;
        logic sum;
        logic mxr;
    } vmemStateT;

    typedef struct packed {
        logic  valid;
        memOpE opcode;
        vaddrT srcA;
        vaddrT srcB;
        tagT   tag;
    } memOpT;

    typedef struct packed {
        logic       valid;
        tagT        tag;
        vaddrT      phys;
        logic [1:0] size;
        logic       signExtend;
        logic       isStore;
        logic [3:0] wmask;
        exceptE     exception;
    } aguResT;

    typedef struct packed {
        logic valid;
        vpnT  vpn;
    } walkReqT;

    // rwx is ordered {R, W, X}
    typedef struct packed {
        logic       valid;
        vpnT        vpn;
        ppnT        ppn;
        logic [2:0] rwx;
        logic       user;
        logic       pageFault;
    } tlbFillT;

endpackage

/* hdl/addrGenUnit.sv */
`timescale 1ns/1ps

module addrGenUnit
    import aguPkg::*;
#(
    parameter vaddrT physLimit = 32'h8000_0000
) (
    input  logic       clk,
    input  logic       rst,
    input  vmemStateT  vmem,
    input  memOpT      op,
    output logic       stall,
    output aguResT     res,
    output vpnT        lookupVpn,
    input  logic       tlbHit,
    input  ppnT        tlbPpn,
    input  logic [2:0] tlbRwx,
    input  logic       tlbUser,
    input  logic       tlbPageFault,
    output walkReqT    walkReq,
    input  logic       fillDone
);

    function automatic logic permFault(input logic [2:0] rwx, input logic pteUser,
                                       input logic store, input vmemStateT vm);
        logic readable;
        logic denied;
        readable = rwx[2] || (rwx[0] && vm.mxr);
        denied = store ? !rwx[1] : !readable;
        if (vm.priv == privUser && !pteUser)
            denied = 1'b1;
        if (vm.priv == privSupervisor && pteUser && !vm.sum)
            denied = 1'b1;
        return denied;
    endfunction

    memOpT  issue;
    memOpT  slot;
    logic   slotValid;
    logic   walkPending;
    logic   replayGo;
    vaddrT  addr;
    vaddrT  slotAddr;
    vaddrT  phys;
    logic   misalign;
    logic   miss;
    aguResT resC;

    assign stall = slotValid;

    // Replay slot takes the issue slot the cycle after its fill
    always_comb begin
        issue = replayGo ? slot : op;
        issue.valid = replayGo || (op.valid && !slotValid);
    end

    assign addr = issue.srcA + issue.srcB;
    assign slotAddr = slot.srcA + slot.srcB;
    assign lookupVpn = addr[31:12];
    assign phys = (vmem.sv32en && tlbHit) ? {tlbPpn, addr[11:0]} : addr;

    always_comb begin
        resC = '0;
        resC.tag = issue.tag;
        resC.phys = phys;
        resC.isStore = issue.opcode inside {SB, SH, SW};
        case (issue.opcode)
            LB: begin
                resC.signExtend = 1'b1;
            end
            LH: begin
                resC.size = 2'd1;
                resC.signExtend = 1'b1;
            end
            LHU, SH: resC.size = 2'd1;
            LW, SW:  resC.size = 2'd2;
            default: ;
        endcase

        // Loads carry no write mask
        if (resC.isStore) begin
            case (resC.size)
                2'd0:    resC.wmask = 4'b0001 << addr[1:0];
                2'd1:    resC.wmask = addr[1] ? 4'b1100 : 4'b0011;
                default: resC.wmask = 4'b1111;
            endcase
        end

        misalign = (resC.size == 2'd1 && addr[0]) ||
                   (resC.size == 2'd2 && addr[1:0] != 2'b00);
        miss = issue.valid && vmem.sv32en && !misalign && !tlbHit;

        if (misalign)
            resC.exception = exMisalign;
        else if (vmem.sv32en &&
                 (tlbPageFault || permFault(tlbRwx, tlbUser, resC.isStore, vmem)))
            resC.exception = exPageFault;
        else if (phys >= physLimit)
            resC.exception = exAccessFault;
        else
            resC.exception = exNone;

        resC.valid = issue.valid && !miss;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= 1'b0;
            walkPending <= 1'b0;
            replayGo <= 1'b0;
        end else begin
            replayGo <= fillDone;
            if (miss) begin
                slotValid <= 1'b1;
                walkPending <= 1'b1;
            end else if (replayGo) begin
                slotValid <= 1'b0;
            end
            if (fillDone)
                walkPending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (miss)
            slot <= issue;
    end

    always_ff @(posedge clk) begin
        res <= resC;
        if (rst)
            res.valid <= 1'b0;
    end

    assign walkReq = '{valid: walkPending, vpn: slotAddr[31:12]};

    assert property (@(posedge clk) disable iff (rst) stall |-> !op.valid)
        else $error("operation presented while stall is high");
    assert property (@(posedge clk) disable iff (rst) walkReq.valid && !fillDone |=> walkReq.valid)
        else $error("walk request dropped before its fill");
    assert property (@(posedge clk) disable iff (rst) fillDone |-> walkReq.valid)
        else $error("fill routed to a unit with no walk outstanding");

endmodule

/* hdl/dataTlb.sv */
`timescale 1ns/1ps

module dataTlb
    import aguPkg::*;
#(
    parameter int tlbEntries = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  vpnT        lookupVpn,
    output logic       hit,
    output ppnT        ppn,
    output logic [2:0] rwx,
    output logic       user,
    output logic       pageFault,
    input  tlbFillT    fill
);

    localparam int idxW = (tlbEntries > 1) ? $clog2(tlbEntries) : 1;

    logic [tlbEntries-1:0] entryValid;
    vpnT                   entryVpn [tlbEntries];
    ppnT                   entryPpn [tlbEntries];
    logic [2:0]            entryRwx [tlbEntries];
    logic                  entryUser [tlbEntries];
    logic                  entryFault [tlbEntries];
    logic [idxW-1:0]       fillPtr;
    logic                  noDup;

    always_comb begin
        hit = 1'b0;
        ppn = '0;
        rwx = '0;
        user = 1'b0;
        pageFault = 1'b0;
        for (int i = 0; i < tlbEntries; i++) begin
            if (entryValid[i] && entryVpn[i] == lookupVpn) begin
                hit = 1'b1;
                ppn = entryPpn[i];
                rwx = entryRwx[i];
                user = entryUser[i];
                pageFault = entryFault[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            fillPtr <= '0;
        end else if (fill.valid) begin
            entryValid[fillPtr] <= 1'b1;
            fillPtr <= (fillPtr == idxW'(tlbEntries - 1)) ? '0 : fillPtr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.valid) begin
            entryVpn[fillPtr] <= fill.vpn;
            entryPpn[fillPtr] <= fill.ppn;
            entryRwx[fillPtr] <= fill.rwx;
            entryUser[fillPtr] <= fill.user;
            entryFault[fillPtr] <= fill.pageFault;
        end
    end

    // Units only walk on a miss, so a vpn is never filled twice
    always_comb begin
        noDup = 1'b1;
        for (int i = 0; i < tlbEntries; i++) begin
            for (int j = i + 1; j < tlbEntries; j++) begin
                if (entryValid[i] && entryValid[j] && entryVpn[i] == entryVpn[j])
                    noDup = 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) noDup)
        else $error("duplicate vpn in TLB");

endmodule

/* hdl/walkArbiter.sv */
`timescale 1ns/1ps

module walkArbiter
    import aguPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  walkReqT reqA,
    input  walkReqT reqB,
    output walkReqT walkReq,
    input  tlbFillT fillIn,
    output tlbFillT fillA,
    output tlbFillT fillB
);

    logic busy;
    // Current grant while busy, last served side otherwise
    logic lastB;
    logic otherReq;
    logic sameReq;

    assign otherReq = lastB ? reqA.valid : reqB.valid;
    assign sameReq = lastB ? reqB.valid : reqA.valid;

    // Fill cycle hands over straight to a waiting peer
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            lastB <= 1'b0;
        end else if (!busy || fillIn.valid) begin
            if (otherReq) begin
                busy <= 1'b1;
                lastB <= !lastB;
            end else begin
                busy <= sameReq && !busy;
            end
        end
    end

    assign walkReq = '{valid: busy, vpn: lastB ? reqB.vpn : reqA.vpn};

    always_comb begin
        fillA = fillIn;
        fillA.valid = fillIn.valid && busy && !lastB;
        fillB = fillIn;
        fillB.valid = fillIn.valid && busy && lastB;
    end

    assert property (@(posedge clk) disable iff (rst) fillIn.valid |-> busy)
        else $error("walker fill without a grant");

endmodule

/* hdl/pageWalker.sv */
`timescale 1ns/1ps

module pageWalker
    import aguPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  vmemStateT vmem,
    input  walkReqT   req,
    output logic      memReq,
    output vaddrT     memAddr,
    input  pteT       memData,
    output tlbFillT   fill
);

    walkStateE  state;
    vpnT        walkVpn;
    ppnT        pteppn;
    logic [2:0] leafRwx;
    logic       leafUser;
    logic       leafFault;
    logic       leaf;
    logic       badPte;

    // PTE bits: V=0 R=1 W=2 X=3 U=4
    assign leaf = memData[1] || memData[3];
    assign badPte = !memData[0] || (memData[2] && !memData[1]);

    assign memReq = (state == wsLevel1Req) || (state == wsLevel0Req);

    always_comb begin
        if (state == wsLevel0Req)
            memAddr = {pteppn, 12'h000} + {20'h0, walkVpn[9:0], 2'b00};
        else
            memAddr = {vmem.rootPpn, 12'h000} + {20'h0, walkVpn[19:10], 2'b00};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wsIdle;
        end else begin
            case (state)
                wsIdle: begin
                    if (req.valid)
                        state <= wsLevel1Req;
                end
                wsLevel1Req:  state <= wsLevel1Wait;
                wsLevel1Wait: state <= (badPte || leaf) ? wsFill : wsLevel0Req;
                wsLevel0Req:  state <= wsLevel0Wait;
                wsLevel0Wait: state <= wsFill;
                default:      state <= wsIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            wsIdle: walkVpn <= req.vpn;
            wsLevel1Wait: begin
                pteppn <= memData[29:10];
                // Leaf at level 1 would be a superpage
                leafFault <= badPte || leaf;
            end
            wsLevel0Wait: begin
                pteppn <= memData[29:10];
                leafRwx <= {memData[1], memData[2], memData[3]};
                leafUser <= memData[4];
                leafFault <= badPte || !leaf;
            end
            default: ;
        endcase
    end

    always_comb begin
        fill.valid = (state == wsFill);
        fill.vpn = walkVpn;
        fill.ppn = pteppn;
        fill.rwx = leafRwx;
        fill.user = leafUser;
        fill.pageFault = leafFault;
    end

endmodule

/* hdl/translateTop.sv */
`timescale 1ns/1ps

module translateTop
    import aguPkg::*;
#(
    parameter vaddrT physLimit = 32'h8000_0000,
    parameter int tlbEntries = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  vmemStateT vmem,
    input  memOpT     loadOp,
    input  memOpT     storeOp,
    output logic      loadStall,
    output logic      storeStall,
    output aguResT    loadRes,
    output aguResT    storeRes,
    output logic      memReq,
    output vaddrT     memAddr,
    input  pteT       memData
);

    vpnT        loadVpn;
    vpnT        storeVpn;
    logic       loadHit;
    logic       storeHit;
    ppnT        loadPpn;
    ppnT        storePpn;
    logic [2:0] loadRwx;
    logic [2:0] storeRwx;
    logic       loadUser;
    logic       storeUser;
    logic       loadPf;
    logic       storePf;
    walkReqT    loadWalk;
    walkReqT    storeWalk;
    walkReqT    walkReq;
    tlbFillT    walkerFill;
    tlbFillT    loadFill;
    tlbFillT    storeFill;

    addrGenUnit #(.physLimit(physLimit)) i_loadAgu (
        .clk(clk), .rst(rst), .vmem(vmem), .op(loadOp), .stall(loadStall), .res(loadRes),
        .lookupVpn(loadVpn), .tlbHit(loadHit), .tlbPpn(loadPpn), .tlbRwx(loadRwx),
        .tlbUser(loadUser), .tlbPageFault(loadPf), .walkReq(loadWalk),
        .fillDone(loadFill.valid)
    );

    addrGenUnit #(.physLimit(physLimit)) i_storeAgu (
        .clk(clk), .rst(rst), .vmem(vmem), .op(storeOp), .stall(storeStall), .res(storeRes),
        .lookupVpn(storeVpn), .tlbHit(storeHit), .tlbPpn(storePpn), .tlbRwx(storeRwx),
        .tlbUser(storeUser), .tlbPageFault(storePf), .walkReq(storeWalk),
        .fillDone(storeFill.valid)
    );

    dataTlb #(.tlbEntries(tlbEntries)) i_loadTlb (
        .clk(clk), .rst(rst), .lookupVpn(loadVpn), .hit(loadHit), .ppn(loadPpn),
        .rwx(loadRwx), .user(loadUser), .pageFault(loadPf), .fill(loadFill)
    );

    dataTlb #(.tlbEntries(tlbEntries)) i_storeTlb (
        .clk(clk), .rst(rst), .lookupVpn(storeVpn), .hit(storeHit), .ppn(storePpn),
        .rwx(storeRwx), .user(storeUser), .pageFault(storePf), .fill(storeFill)
    );

    walkArbiter i_walkArb (
        .clk(clk), .rst(rst), .reqA(loadWalk), .reqB(storeWalk), .walkReq(walkReq),
        .fillIn(walkerFill), .fillA(loadFill), .fillB(storeFill)
    );

    pageWalker i_walker (
        .clk(clk), .rst(rst), .vmem(vmem), .req(walkReq), .memReq(memReq),
        .memAddr(memAddr), .memData(memData), .fill(walkerFill)
    );

endmodule

/* test/translateTb.sv */
`timescale 1ns/1ps

module translateTb
    import aguPkg::*;
;

    localparam vaddrT physLimit = 32'h8000_0000;
    localparam int    numOps = 50;
    localparam ppnT   rootPpn = 20'h00010;

    // Virtual pages behind the level-0 table at 0x11000
    localparam vaddrT pageA = 32'h0040_0000;
    localparam vaddrT pageB = 32'h0040_1000;
    localparam vaddrT pageC = 32'h0040_2000;
    localparam vaddrT pageD = 32'h0040_3000;
    localparam vaddrT pageE = 32'h0040_4000;
    localparam vaddrT pageBad = 32'h0080_0000;

    logic      clk;
    logic      rst;
    vmemStateT vmem;
    memOpT     loadOp;
    memOpT     storeOp;
    logic      loadStall;
    logic      storeStall;
    aguResT    loadRes;
    aguResT    storeRes;
    logic      memReq;
    vaddrT     memAddr;
    pteT       memData;

    pteT    ptMem [16384];
    aguResT expLoad [64];
    aguResT expStore [64];
    tagT    nextTag;

    translateTop #(.physLimit(physLimit), .tlbEntries(4)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Page-table memory with one cycle read latency
    always @(posedge clk) begin
        if (memReq)
            memData <= ptMem[memAddr[15:2]];
    end

    task automatic failRun(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    function automatic pteT readPte(input vaddrT addr);
        return ptMem[addr[15:2]];
    endfunction

    function automatic pteT leafPte(input ppnT ppn, input logic [4:0] flags);
        return {2'b00, ppn, 5'b00000, flags};
    endfunction

    task automatic buildTable();
        // Background words all have V clear
        for (int i = 0; i < 16384; i++)
            ptMem[i] = {i[13:0], 18'h0};
        ptMem[32'h10004 >> 2] = 32'h0000_4401;
        ptMem[32'h10008 >> 2] = 32'h0;
        ptMem[32'h11000 >> 2] = leafPte(20'h00200, 5'h17);
        ptMem[32'h11004 >> 2] = leafPte(20'h00300, 5'h07);
        ptMem[32'h11008 >> 2] = leafPte(20'h00400, 5'h13);
        ptMem[32'h1100c >> 2] = leafPte(20'h90000, 5'h07);
        ptMem[32'h11010 >> 2] = leafPte(20'h00500, 5'h17);
    endtask

    function automatic aguResT expectOp(input memOpT m);
        aguResT     e;
        vaddrT      va;
        pteT        p1;
        pteT        p0;
        logic [1:0] align;
        logic       deny;
        e = '0;
        e.valid = 1'b1;
        e.tag = m.tag;
        va = m.srcA + m.srcB;
        e.phys = va;
        e.isStore = m.opcode inside {SB, SH, SW};
        e.signExtend = m.opcode inside {LB, LH};
        if (m.opcode inside {LH, LHU, SH})
            e.size = 2'd1;
        else if (m.opcode inside {LW, SW})
            e.size = 2'd2;
        align = (e.size == 2'd0) ? va[1:0] : (e.size == 2'd1) ? {va[1], 1'b0} : 2'b00;
        if (e.isStore)
            e.wmask = (e.size == 2'd0) ? 4'b0001 << align :
                      (e.size == 2'd1) ? 4'b0011 << align : 4'b1111;
        if ((e.size == 2'd1 && va[0]) || (e.size == 2'd2 && va[1:0] != 2'b00)) begin
            e.exception = exMisalign;
            return e;
        end
        if (vmem.sv32en) begin
            p1 = readPte({vmem.rootPpn, 12'h000} + {20'h0, va[31:22], 2'b00});
            p0 = readPte({p1[29:10], 12'h000} + {20'h0, va[21:12], 2'b00});
            if (!p1[0] || p1[1] || p1[3] || (p1[2] && !p1[1])) begin
                e.exception = exPageFault;
                return e;
            end
            if (!p0[0] || !(p0[1] || p0[3]) || (p0[2] && !p0[1])) begin
                e.exception = exPageFault;
                return e;
            end
            e.phys = {p0[29:10], va[11:0]};
            deny = e.isStore ? !p0[2] : !(p0[1] || (p0[3] && vmem.mxr));
            if (vmem.priv == privUser && !p0[4])
                deny = 1'b1;
            if (vmem.priv == privSupervisor && p0[4] && !vmem.sum)
                deny = 1'b1;
            if (deny) begin
                e.exception = exPageFault;
                return e;
            end
        end
        e.exception = (e.phys >= physLimit) ? exAccessFault : exNone;
        return e;
    endfunction

    function automatic logic resMatches(input aguResT got, input aguResT exp);
        logic ok;
        ok = got.tag == exp.tag && got.size == exp.size && got.signExtend == exp.signExtend &&
             got.isStore == exp.isStore && got.wmask == exp.wmask &&
             got.exception == exp.exception;
        // Address has no meaning once a misalign or page fault is raised
        if (exp.exception == exNone || exp.exception == exAccessFault)
            ok = ok && got.phys == exp.phys;
        return ok;
    endfunction

    assert property (@(posedge clk) disable iff (rst)
        loadRes.valid |-> resMatches(loadRes, expLoad[loadRes.tag]))
        else failRun($sformatf("load result %h, expected %h", loadRes, expLoad[loadRes.tag]));
    assert property (@(posedge clk) disable iff (rst)
        storeRes.valid |-> resMatches(storeRes, expStore[storeRes.tag]))
        else failRun($sformatf("store result %h, expected %h", storeRes,
                               expStore[storeRes.tag]));
    // Fills must match the page each unit is waiting for
    assert property (@(posedge clk) disable iff (rst)
        i_dut.loadFill.valid |-> i_dut.loadFill.vpn == i_dut.loadWalk.vpn)
        else failRun("load unit received a fill for another page");
    assert property (@(posedge clk) disable iff (rst)
        i_dut.storeFill.valid |-> i_dut.storeFill.vpn == i_dut.storeWalk.vpn)
        else failRun("store unit received a fill for another page");
    // An accepted op returns in the next cycle or parks behind stall
    assert property (@(posedge clk) disable iff (rst)
        loadOp.valid && !loadStall |=> loadRes.valid != loadStall)
        else failRun("load unit neither returned a result nor raised stall after acceptance");
    assert property (@(posedge clk) disable iff (rst)
        storeOp.valid && !storeStall |=> storeRes.valid != storeStall)
        else failRun("store unit neither returned a result nor raised stall after acceptance");

    task automatic setVmem(input logic en, input privE p, input logic s);
        @(posedge clk);
        vmem <= '{sv32en: en, rootPpn: rootPpn, priv: p, sum: s, mxr: 1'b0};
    endtask

    task automatic sendOp(input logic store, input memOpE opc, input vaddrT a, input vaddrT b);
        memOpT m;
        m = '{valid: 1'b1, opcode: opc, srcA: a, srcB: b, tag: nextTag};
        if (store) begin
            expStore[nextTag] = expectOp(m);
            storeOp <= m;
        end else begin
            expLoad[nextTag] = expectOp(m);
            loadOp <= m;
        end
        nextTag = nextTag + 1'b1;
    endtask

    // wantLat of zero leaves the latency unchecked
    task automatic runOp(input logic store, input memOpE opc, input vaddrT a, input vaddrT b,
                         input int wantLat);
        int cycles;
        @(posedge clk);
        sendOp(store, opc, a, b);
        @(posedge clk);
        if (store)
            storeOp.valid <= 1'b0;
        else
            loadOp.valid <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(store ? storeRes.valid : loadRes.valid));
        if (wantLat > 0)
            assert (cycles == wantLat)
                else failRun($sformatf("result after %0d cycles, expected %0d", cycles, wantLat));
    endtask

    initial begin
        repeat (numOps * 20) @(posedge clk);
        $display("Timeout: results stopped arriving before all operations finished");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        vaddrT pages [5];
        memOpE loadOps [5];
        memOpE storeOps [3];
        logic [31:0] r;
        pages = '{pageA, pageB, pageC, pageD, pageE};
        loadOps = '{LB, LH, LW, LBU, LHU};
        storeOps = '{SB, SH, SW};
        void'($urandom(81));
        buildTable();
        nextTag = '0;
        rst <= 1'b1;
        vmem <= '0;
        loadOp <= '0;
        storeOp <= '0;
        memData <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Bare mode decode
        setVmem(1'b0, privSupervisor, 1'b0);
        runOp(1'b0, LB, 32'h1000, 32'h3, 1);
        runOp(1'b0, LH, 32'h2000, 32'h2, 1);
        runOp(1'b0, LW, 32'h3000, 32'h4, 1);
        runOp(1'b0, LBU, 32'h1001, 32'h0, 1);
        runOp(1'b0, LHU, 32'h1002, 32'h0, 1);
        runOp(1'b1, SB, 32'h2000, 32'h1, 1);
        runOp(1'b1, SH, 32'h2002, 32'h0, 1);
        runOp(1'b1, SW, 32'h4000, 32'h8, 1);
        runOp(1'b0, LW, 32'h9000_0000, 32'h0, 1);
        runOp(1'b0, LH, 32'h1001, 32'h0, 1);
        runOp(1'b0, LW, 32'h1002, 32'h0, 1);
        runOp(1'b1, SH, 32'h1003, 32'h0, 1);
        runOp(1'b1, SW, 32'h1001, 32'h0, 1);

        // Translated accesses in user mode
        setVmem(1'b1, privUser, 1'b0);
        runOp(1'b0, LW, pageA, 32'h10, 0);
        runOp(1'b0, LW, pageA, 32'h20, 1);
        runOp(1'b1, SW, pageA, 32'h30, 0);
        runOp(1'b1, SB, pageA, 32'h31, 1);
        runOp(1'b0, LW, pageBad, 32'h0, 0);
        runOp(1'b1, SW, pageC, 32'h4, 0);
        runOp(1'b0, LW, pageC, 32'h4, 0);
        runOp(1'b0, LW, pageD, 32'h0, 0);
        runOp(1'b0, LH, pageA, 32'h1, 1);
        runOp(1'b1, SW, pageE, 32'h2, 1);

        // Supervisor access to a user page before and after setting sum
        setVmem(1'b1, privSupervisor, 1'b0);
        runOp(1'b0, LW, pageA, 32'h8, 1);
        setVmem(1'b1, privSupervisor, 1'b1);
        runOp(1'b0, LW, pageA, 32'h8, 1);
        runOp(1'b0, LW, pageD, 32'h40, 1);
        runOp(1'b1, SW, pageB, 32'hc, 0);

        // Both units miss together
        fork
            runOp(1'b0, LW, pageB, 32'h44, 0);
            runOp(1'b1, SW, pageE, 32'h48, 0);
        join

        repeat (20) begin
            r = $urandom;
            if (r[0])
                runOp(1'b1, storeOps[int'(r[31:20]) % 3], pages[int'(r[19:16]) % 5],
                      {20'h0, r[12:1]}, 0);
            else
                runOp(1'b0, loadOps[int'(r[31:20]) % 5], pages[int'(r[19:16]) % 5],
                      {20'h0, r[12:1]}, 0);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

/* verilog.f */
hdl/aguPkg.sv
hdl/addrGenUnit.sv
hdl/dataTlb.sv
hdl/walkArbiter.sv
hdl/pageWalker.sv
hdl/translateTop.sv
test/translateTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= translateTb
BUILD ?= obj_dir
LOG ?= sim.log
FLIST ?= verilog.f
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
